/* include/sampler_macros.svh */
// fixed widths and constants of the coefficient sampler
`ifndef SAMPLER_MACROS_SVH
`define SAMPLER_MACROS_SVH

// modulus q and coefficient width
`define SAMPLER_Q 23'd8380417
`define SAMPLER_Q_W 23

// stream, sample word and buffer widths
`define SAMPLER_STREAM_W 64
`define SAMPLER_SAMPLE_W 24
`define SAMPLER_BUF_W 128

// bounded mode nibbles and bound eta
`define SAMPLER_NIBBLES 6
`define SAMPLER_ETA 2

// output beats
`define SAMPLER_LANES 4
`define SAMPLER_GROUPS 64

// destination memory address
`define SAMPLER_ADDR_W 10

`endif

/* hw/sampler_pkg.sv */
// sampler types: rejection mode, coefficient and sample word views
package sampler_pkg;

  typedef enum logic {
    SAMPLER_REJ_UNIFORM = 1'b0,
    SAMPLER_REJ_BOUNDED = 1'b1
  } sampler_mode_e;

  // one coefficient mod q
  typedef logic [22:0] coeff_t;

  // uniform view, one 23-bit candidate
  typedef struct packed {
    logic       spare;
    logic [22:0] cand;
  } sample_uni_t;

  // one sample word, read by the uniform or the bounded sampler
  typedef union packed {
    sample_uni_t     uni;
    logic [5:0][3:0] nib;
  } sample_word_u;

endpackage

/* hw/sampler_piso.sv */
// parallel-in serial-out buffer, 64-bit stream words to 24-bit sample words
`timescale 1ns/100ps
`include "sampler_macros.svh"

module sampler_piso (
  input  logic                         clk,
  input  logic                         rst_b,
  input  logic                         flush_i,
  input  logic                         running_i,
  input  logic                         stream_valid_i,
  input  logic [`SAMPLER_STREAM_W-1:0] stream_data_i,
  output logic                         stream_hold_o,
  output logic                         piso_valid_o,
  output sampler_pkg::sample_word_u    piso_word_o,
  input  logic                         piso_hold_i
);
  import sampler_pkg::*;

  logic [`SAMPLER_BUF_W-1:0]            buf_q;
  logic [`SAMPLER_BUF_W-1:0]            buf_shift;
  logic [`SAMPLER_BUF_W-1:0]            buf_n;
  logic [$clog2(`SAMPLER_BUF_W+1)-1:0] cnt_q;
  logic [$clog2(`SAMPLER_BUF_W+1)-1:0] cnt_shift;
  logic [$clog2(`SAMPLER_BUF_W+1)-1:0] cnt_n;
  logic                                 pop;
  logic                                 push;

  assign piso_valid_o  = (cnt_q >= `SAMPLER_SAMPLE_W);
  assign piso_word_o   = sample_word_u'(buf_q[`SAMPLER_SAMPLE_W-1:0]);
  // room for one more stream word only at 64 bits or less
  assign stream_hold_o = (cnt_q > `SAMPLER_STREAM_W) | ~running_i;

  assign pop  = piso_valid_o & ~piso_hold_i;
  assign push = stream_valid_i & ~stream_hold_o;

  always_comb begin
    buf_shift = pop ? (buf_q >> `SAMPLER_SAMPLE_W) : buf_q;
    cnt_shift = pop ? (cnt_q - `SAMPLER_SAMPLE_W) : cnt_q;
    buf_n     = buf_shift;
    cnt_n     = cnt_shift;
    // new word lands just above the bits still held
    if (push) begin
      buf_n = buf_shift |
              ({{(`SAMPLER_BUF_W-`SAMPLER_STREAM_W){1'b0}}, stream_data_i} << cnt_shift);
      cnt_n = cnt_shift + `SAMPLER_STREAM_W;
    end
  end

  // bits above cnt_q stay zero so that the append is a plain or
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buf_q <= '0;
      cnt_q <= '0;
    end else if (flush_i) begin
      buf_q <= '0;
      cnt_q <= '0;
    end else begin
      buf_q <= buf_n;
      cnt_q <= cnt_n;
    end
  end

endmodule

/* hw/sampler_reject.sv */
// rejection test of sample words in uniform or bounded mode, one register stage
`timescale 1ns/100ps
`include "sampler_macros.svh"

module sampler_reject (
  input  logic                                         clk,
  input  logic                                         rst_b,
  input  logic                                         flush_i,
  input  sampler_pkg::sampler_mode_e                   mode_i,
  input  logic                                         piso_valid_i,
  input  sampler_pkg::sample_word_u                    piso_word_i,
  output logic                                         piso_hold_o,
  output logic                                         cand_valid_o,
  output logic [2:0]                                   cand_count_o,
  output sampler_pkg::coeff_t [`SAMPLER_NIBBLES-1:0]   cand_coeffs_o,
  input  logic                                         cand_hold_i
);
  import sampler_pkg::*;

  logic [2:0]                   acc_cnt;
  coeff_t [`SAMPLER_NIBBLES-1:0] acc_coeffs;

  // nibble mod 5 gives eta minus r, negatives wrap to q plus value
  function automatic coeff_t bound_map(input logic [3:0] nib);
    logic [2:0] r;
    r = 3'(nib % 4'd5);
    if (r <= `SAMPLER_ETA) begin
      bound_map = coeff_t'(`SAMPLER_ETA) - coeff_t'(r);
    end else begin
      bound_map = `SAMPLER_Q + coeff_t'(`SAMPLER_ETA) - coeff_t'(r);
    end
  endfunction

  assign piso_hold_o = cand_valid_o & cand_hold_i;

  always_comb begin
    acc_cnt    = '0;
    acc_coeffs = '0;
    if (mode_i == SAMPLER_REJ_UNIFORM) begin
      if (piso_word_i.uni.cand < `SAMPLER_Q) begin
        acc_coeffs[0] = piso_word_i.uni.cand;
        acc_cnt       = 3'd1;
      end
    end else begin
      // nibbles of 15 are rejected, survivors packed into low lanes
      for (int i = 0; i < `SAMPLER_NIBBLES; i++) begin
        if (piso_word_i.nib[i] < 4'd15) begin
          acc_coeffs[acc_cnt] = bound_map(piso_word_i.nib[i]);
          acc_cnt             = acc_cnt + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      cand_valid_o <= 1'b0;
    end else if (flush_i) begin
      cand_valid_o <= 1'b0;
    end else if (!piso_hold_o) begin
      cand_valid_o <= piso_valid_i & (acc_cnt != 3'd0);
    end
  end

  always_ff @(posedge clk) begin
    if (!piso_hold_o) begin
      cand_count_o  <= acc_cnt;
      cand_coeffs_o <= acc_coeffs;
    end
  end

endmodule

/* hw/coeff_packer.sv */
// coefficient packer, collects accepted coefficients into four-lane beats
`timescale 1ns/100ps
`include "sampler_macros.svh"

module coeff_packer (
  input  logic                                       clk,
  input  logic                                       rst_b,
  input  logic                                       flush_i,
  input  logic                                       cand_valid_i,
  input  logic [2:0]                                 cand_count_i,
  input  sampler_pkg::coeff_t [`SAMPLER_NIBBLES-1:0] cand_coeffs_i,
  output logic                                       cand_hold_o,
  output logic                                       pack_valid_o,
  output sampler_pkg::coeff_t [`SAMPLER_LANES-1:0]   pack_coeffs_o
);
  import sampler_pkg::*;

  // up to three left over plus a full group of six
  coeff_t [`SAMPLER_LANES+`SAMPLER_NIBBLES-2:0] buf_q;
  coeff_t [`SAMPLER_LANES+`SAMPLER_NIBBLES-2:0] buf_n;
  logic [3:0]                                   fill_q;
  logic [3:0]                                   fill_n;
  logic                                         pop;
  logic                                         push;

  assign cand_hold_o = (fill_q >= `SAMPLER_LANES);
  assign pop         = cand_hold_o;
  assign push        = cand_valid_i & ~cand_hold_o;

  // pop and push never meet, a group only enters below four
  always_comb begin
    buf_n  = buf_q;
    fill_n = fill_q;
    if (pop) begin
      buf_n  = buf_q >> (`SAMPLER_LANES * `SAMPLER_Q_W);
      fill_n = fill_q - 4'(`SAMPLER_LANES);
    end else if (push) begin
      for (int i = 0; i < `SAMPLER_NIBBLES; i++) begin
        if (i < cand_count_i) begin
          buf_n[fill_q + 4'(i)] = cand_coeffs_i[i];
        end
      end
      fill_n = fill_q + 4'(cand_count_i);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fill_q       <= '0;
      pack_valid_o <= 1'b0;
    end else if (flush_i) begin
      fill_q       <= '0;
      pack_valid_o <= 1'b0;
    end else begin
      fill_q       <= fill_n;
      pack_valid_o <= pop;
    end
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_n;
    // oldest four go out, lane 0 first
    if (pop) begin
      pack_coeffs_o <= buf_q[`SAMPLER_LANES-1:0];
    end
  end

endmodule

/* hw/sampler_ctrl.sv */
// run FSM, beat counter, destination address and output steering
`timescale 1ns/100ps
`include "sampler_macros.svh"

module sampler_ctrl (
  input  logic                                     clk,
  input  logic                                     rst_b,
  input  logic                                     zeroize_i,
  input  logic                                     start_i,
  input  sampler_pkg::sampler_mode_e               mode_i,
  input  logic [`SAMPLER_ADDR_W-1:0]               dest_base_addr_i,
  input  logic                                     pack_valid_i,
  input  sampler_pkg::coeff_t [`SAMPLER_LANES-1:0] pack_coeffs_i,
  output sampler_pkg::sampler_mode_e               run_mode_o,
  output logic                                     running_o,
  output logic                                     flush_o,
  output logic                                     busy_o,
  output logic                                     done_o,
  output logic                                     ntt_dv_o,
  output sampler_pkg::coeff_t [`SAMPLER_LANES-1:0] ntt_data_o,
  output logic                                     mem_dv_o,
  output sampler_pkg::coeff_t [`SAMPLER_LANES-1:0] mem_data_o,
  output logic [`SAMPLER_ADDR_W-1:0]               mem_addr_o
);
  import sampler_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_RUN  = 2'b01,
    ST_DONE = 2'b10
  } ctrl_state_e;

  ctrl_state_e                         state_q;
  ctrl_state_e                         state_n;
  logic [$clog2(`SAMPLER_GROUPS)-1:0] beat_cnt_q;
  logic                                start_ok;
  logic                                beat;

  assign running_o  = (state_q == ST_RUN);
  assign start_ok   = start_i & ~running_o;
  assign beat       = running_o & pack_valid_i;
  assign done_o     = beat & (beat_cnt_q == `SAMPLER_GROUPS - 1);
  assign flush_o    = done_o | zeroize_i;
  assign busy_o     = start_i | running_o;

  assign ntt_dv_o   = beat & (run_mode_o == SAMPLER_REJ_UNIFORM);
  assign ntt_data_o = pack_coeffs_i;
  assign mem_dv_o   = beat & (run_mode_o == SAMPLER_REJ_BOUNDED);
  assign mem_data_o = pack_coeffs_i;

  // done lasts one cycle and takes a new start like idle
  always_comb begin
    state_n = state_q;
    case (state_q)
      ST_IDLE, ST_DONE: state_n = start_i ? ST_RUN : ST_IDLE;
      ST_RUN:           state_n = done_o ? ST_DONE : ST_RUN;
      default:          state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q    <= ST_IDLE;
      run_mode_o <= SAMPLER_REJ_UNIFORM;
      beat_cnt_q <= '0;
      mem_addr_o <= '0;
    end else if (zeroize_i) begin
      state_q    <= ST_IDLE;
      run_mode_o <= SAMPLER_REJ_UNIFORM;
      beat_cnt_q <= '0;
      mem_addr_o <= '0;
    end else begin
      state_q <= state_n;
      if (start_ok) begin
        run_mode_o <= mode_i;
        beat_cnt_q <= '0;
        mem_addr_o <= dest_base_addr_i;
      end else if (beat) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        mem_addr_o <= mem_addr_o + 1'b1;
      end
    end
  end

endmodule

/* hw/sampler_top.sv */
// sampler top level: piso, rejection stage, packer and run control
`timescale 1ns/100ps
`include "sampler_macros.svh"

module sampler_top (
  input  logic                                     clk,
  input  logic                                     rst_b,
  input  logic                                     zeroize_i,
  input  logic                                     start_i,
  input  sampler_pkg::sampler_mode_e               mode_i,
  input  logic [`SAMPLER_ADDR_W-1:0]               dest_base_addr_i,
  input  logic                                     stream_valid_i,
  input  logic [`SAMPLER_STREAM_W-1:0]             stream_data_i,
  output logic                                     stream_hold_o,
  output logic                                     busy_o,
  output logic                                     done_o,
  output logic                                     ntt_dv_o,
  output sampler_pkg::coeff_t [`SAMPLER_LANES-1:0] ntt_data_o,
  output logic                                     mem_dv_o,
  output sampler_pkg::coeff_t [`SAMPLER_LANES-1:0] mem_data_o,
  output logic [`SAMPLER_ADDR_W-1:0]               mem_addr_o
);
  import sampler_pkg::*;

  logic                          piso_valid;
  logic                          piso_hold;
  sample_word_u                  piso_word;
  logic                          cand_valid;
  logic                          cand_hold;
  logic [2:0]                    cand_count;
  coeff_t [`SAMPLER_NIBBLES-1:0] cand_coeffs;
  logic                          pack_valid;
  coeff_t [`SAMPLER_LANES-1:0]   pack_coeffs;
  logic                          flush;
  logic                          running;
  sampler_mode_e                 run_mode;

  sampler_piso i_piso (
    .clk            (clk),
    .rst_b          (rst_b),
    .flush_i        (flush),
    .running_i      (running),
    .stream_valid_i (stream_valid_i),
    .stream_data_i  (stream_data_i),
    .stream_hold_o  (stream_hold_o),
    .piso_valid_o   (piso_valid),
    .piso_word_o    (piso_word),
    .piso_hold_i    (piso_hold)
  );

  sampler_reject i_reject (
    .clk           (clk),
    .rst_b         (rst_b),
    .flush_i       (flush),
    .mode_i        (run_mode),
    .piso_valid_i  (piso_valid),
    .piso_word_i   (piso_word),
    .piso_hold_o   (piso_hold),
    .cand_valid_o  (cand_valid),
    .cand_count_o  (cand_count),
    .cand_coeffs_o (cand_coeffs),
    .cand_hold_i   (cand_hold)
  );

  coeff_packer i_packer (
    .clk           (clk),
    .rst_b         (rst_b),
    .flush_i       (flush),
    .cand_valid_i  (cand_valid),
    .cand_count_i  (cand_count),
    .cand_coeffs_i (cand_coeffs),
    .cand_hold_o   (cand_hold),
    .pack_valid_o  (pack_valid),
    .pack_coeffs_o (pack_coeffs)
  );

  sampler_ctrl i_ctrl (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .start_i          (start_i),
    .mode_i           (mode_i),
    .dest_base_addr_i (dest_base_addr_i),
    .pack_valid_i     (pack_valid),
    .pack_coeffs_i    (pack_coeffs),
    .run_mode_o       (run_mode),
    .running_o        (running),
    .flush_o          (flush),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .ntt_dv_o         (ntt_dv_o),
    .ntt_data_o       (ntt_data_o),
    .mem_dv_o         (mem_dv_o),
    .mem_data_o       (mem_data_o),
    .mem_addr_o       (mem_addr_o)
  );

endmodule

/* test/sampler_tb.sv */
// testbench for sampler_top with random stream, bit-level reference model and beat checks
`timescale 1ns/100ps
`include "sampler_macros.svh"

module sampler_tb;
  import sampler_pkg::*;

  // cycle budget per run
  localparam int RUN_BUDGET = 2500;
  localparam int NUM_RUNS   = 8;
  localparam int MAX_CYCLES = RUN_BUDGET * NUM_RUNS;
  localparam int Q          = `SAMPLER_Q;

  logic                         clk;
  logic                         rst_b;
  logic                         zeroize_i;
  logic                         start_i;
  sampler_mode_e                mode_i;
  logic [`SAMPLER_ADDR_W-1:0]   dest_base_addr_i;
  logic                         stream_valid_i;
  logic [`SAMPLER_STREAM_W-1:0] stream_data_i;
  logic                         stream_hold_o;
  logic                         busy_o;
  logic                         done_o;
  logic                         ntt_dv_o;
  coeff_t [`SAMPLER_LANES-1:0]  ntt_data_o;
  logic                         mem_dv_o;
  coeff_t [`SAMPLER_LANES-1:0]  mem_data_o;
  logic [`SAMPLER_ADDR_W-1:0]   mem_addr_o;

  // reference model state
  logic [31:0]                  rng_state;
  logic                         stream_bits[$];
  coeff_t                       exp_coeffs[$];
  sampler_mode_e                exp_mode;
  logic [`SAMPLER_ADDR_W-1:0]   exp_base;
  logic                         active;
  int                           beat_idx;
  int                           cycle_cnt;
  int                           value_errs;
  int                           other_errs;

  sampler_top i_dut (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .start_i          (start_i),
    .mode_i           (mode_i),
    .dest_base_addr_i (dest_base_addr_i),
    .stream_valid_i   (stream_valid_i),
    .stream_data_i    (stream_data_i),
    .stream_hold_o    (stream_hold_o),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .ntt_dv_o         (ntt_dv_o),
    .ntt_data_o       (ntt_data_o),
    .mem_dv_o         (mem_dv_o),
    .mem_data_o       (mem_data_o),
    .mem_addr_o       (mem_addr_o)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_coeff(input string name, input int lane, input coeff_t act,
                             input coeff_t want);
    if (act !== want) begin
      value_errs++;
      $display("error: %s[%0d] is 0x%06h, expected 0x%06h", name, lane, act, want);
    end
  endtask

  task automatic check_addr(input logic [`SAMPLER_ADDR_W-1:0] act,
                            input logic [`SAMPLER_ADDR_W-1:0] want);
    if (act !== want) begin
      value_errs++;
      $display("error: mem_addr_o is 0x%03h, expected 0x%03h", act, want);
    end
  endtask

  task automatic expect_flag(input string name, input logic act, input logic want);
    if (act !== want) begin
      value_errs++;
      $display("error: %s is 0x%h, expected 0x%h", name, act, want);
    end
  endtask

  // acceptance rules of the scheme on one 24-bit sample word
  task automatic decode_sample(input logic [`SAMPLER_SAMPLE_W-1:0] w);
    int nib;
    int val;
    if (exp_mode == SAMPLER_REJ_UNIFORM) begin
      if (int'(w[22:0]) < Q) begin
        exp_coeffs.push_back(w[22:0]);
      end
    end else begin
      for (int i = 0; i < `SAMPLER_NIBBLES; i++) begin
        nib = w[4*i +: 4];
        if (nib < 15) begin
          val = `SAMPLER_ETA - (nib % 5);
          // negative results are stored as q minus the magnitude
          if (val < 0) begin
            val = val + Q;
          end
          exp_coeffs.push_back(coeff_t'(val));
        end
      end
    end
  endtask

  task automatic pop_expected(output coeff_t c);
    logic [`SAMPLER_SAMPLE_W-1:0] w;
    while (exp_coeffs.size() == 0) begin
      if (stream_bits.size() < `SAMPLER_SAMPLE_W) begin
        other_errs++;
        $display("DUT produced a beat before enough stream bits were sent");
        exp_coeffs.push_back('0);
      end else begin
        for (int i = 0; i < `SAMPLER_SAMPLE_W; i++) begin
          w[i] = stream_bits.pop_front();
        end
        decode_sample(w);
      end
    end
    c = exp_coeffs.pop_front();
  endtask

  // outputs seen here belong to the coming rising edge
  task automatic watch_outputs();
    logic                        beat;
    logic                        other;
    coeff_t [`SAMPLER_LANES-1:0] data;
    coeff_t                      want;
    string                       data_name;
    string                       other_name;
    expect_flag("busy_o", busy_o, active);
    if (!active) begin
      expect_flag("stream_hold_o", stream_hold_o, 1'b1);
      expect_flag("ntt_dv_o", ntt_dv_o, 1'b0);
      expect_flag("mem_dv_o", mem_dv_o, 1'b0);
      expect_flag("done_o", done_o, 1'b0);
    end else begin
      if (exp_mode == SAMPLER_REJ_UNIFORM) begin
        beat       = ntt_dv_o;
        other      = mem_dv_o;
        data       = ntt_data_o;
        data_name  = "ntt_data_o";
        other_name = "mem_dv_o";
      end else begin
        beat       = mem_dv_o;
        other      = ntt_dv_o;
        data       = mem_data_o;
        data_name  = "mem_data_o";
        other_name = "ntt_dv_o";
      end
      expect_flag(other_name, other, 1'b0);
      expect_flag("done_o", done_o, beat && (beat_idx == `SAMPLER_GROUPS - 1));
      if (beat) begin
        for (int l = 0; l < `SAMPLER_LANES; l++) begin
          pop_expected(want);
          check_coeff(data_name, l, data[l], want);
        end
        if (exp_mode == SAMPLER_REJ_BOUNDED) begin
          check_addr(mem_addr_o, exp_base + `SAMPLER_ADDR_W'(beat_idx));
        end
        beat_idx++;
      end
    end
  endtask

  task automatic tick(input logic do_start, input logic do_zero);
    logic [31:0] r;
    logic        hold_now;
    logic        flush_next;
    @(negedge clk);
    watch_outputs();
    hold_now   = stream_hold_o;
    flush_next = done_o | do_zero;
    r = next_rand();
    stream_valid_i = (r[1:0] != 2'b00);
    stream_data_i  = {next_rand(), next_rand()};
    start_i        = do_start;
    zeroize_i      = do_zero;
    if (flush_next) begin
      // a word offered on the flush edge is dropped with the rest
      active = 1'b0;
      stream_bits.delete();
      exp_coeffs.delete();
    end else if (stream_valid_i && !hold_now) begin
      for (int i = 0; i < `SAMPLER_STREAM_W; i++) begin
        stream_bits.push_back(stream_data_i[i]);
      end
    end
  endtask

  // zero_at below zero runs to the end
  task automatic run_once(input sampler_mode_e run_mode,
                          input logic [`SAMPLER_ADDR_W-1:0] base, input int zero_at);
    mode_i           = run_mode;
    dest_base_addr_i = base;
    tick(1'b1, 1'b0);
    exp_mode = run_mode;
    exp_base = base;
    beat_idx = 0;
    active   = 1'b1;
    stream_bits.delete();
    exp_coeffs.delete();
    while (active) begin
      if (zero_at >= 0 && beat_idx >= zero_at) begin
        tick(1'b0, 1'b1);
      end else begin
        tick(1'b0, 1'b0);
      end
    end
    if (zero_at < 0 && beat_idx != `SAMPLER_GROUPS) begin
      other_errs++;
      $display("run ended after %0d beats instead of %0d", beat_idx, `SAMPLER_GROUPS);
    end
    // idle gap catches stray beats after a zeroize
    if (zero_at >= 0) begin
      repeat (16) tick(1'b0, 1'b0);
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the runs did not finish within %0d cycles", MAX_CYCLES);
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    clk              = 1'b0;
    rst_b            = 1'b0;
    zeroize_i        = 1'b0;
    start_i          = 1'b0;
    mode_i           = SAMPLER_REJ_UNIFORM;
    dest_base_addr_i = '0;
    stream_valid_i   = 1'b0;
    stream_data_i    = '0;
    rng_state        = 32'h6926_ecc4;
    exp_mode         = SAMPLER_REJ_UNIFORM;
    exp_base         = '0;
    active           = 1'b0;
    beat_idx         = 0;
    value_errs       = 0;
    other_errs       = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_b = 1'b1;
    expect_flag("stream_hold_o", stream_hold_o, 1'b1);
    expect_flag("busy_o", busy_o, 1'b0);
    expect_flag("done_o", done_o, 1'b0);
    expect_flag("ntt_dv_o", ntt_dv_o, 1'b0);
    expect_flag("mem_dv_o", mem_dv_o, 1'b0);

    run_once(SAMPLER_REJ_UNIFORM, 10'h000, -1);
    run_once(SAMPLER_REJ_BOUNDED, 10'h040, -1);
    run_once(SAMPLER_REJ_UNIFORM, 10'h155, -1);
    // base near the top so the address wraps
    run_once(SAMPLER_REJ_BOUNDED, 10'h3e0, -1);
    run_once(SAMPLER_REJ_UNIFORM, 10'h2a0, 5);
    run_once(SAMPLER_REJ_BOUNDED, 10'h100, 20);
    run_once(SAMPLER_REJ_UNIFORM, 10'h080, -1);
    run_once(SAMPLER_REJ_BOUNDED, 10'h200, -1);
    // a few idle cycles after the last done
    repeat (4) tick(1'b0, 1'b0);

    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
hw/sampler_pkg.sv
hw/sampler_piso.sv
hw/sampler_reject.sv
hw/coeff_packer.sv
hw/sampler_ctrl.sv
hw/sampler_top.sv
test/sampler_tb.sv

/* Bender.yml */
package:
  name: sampler

export_include_dirs:
  - include

sources:
  - hw/sampler_pkg.sv
  - hw/sampler_piso.sv
  - hw/sampler_reject.sv
  - hw/coeff_packer.sv
  - hw/sampler_ctrl.sv
  - hw/sampler_top.sv
  - target: test
    files:
      - test/sampler_tb.sv
